/* st_bus_pkg.sv */
/*
 * ST bus package
 * widths of the SDRAM request bundle, bus slot numbers, ROM chip selects
 */
package st_bus_pkg;

	typedef logic [23:1] word_addr_t;	// 68000 style word address
	typedef logic [15:0] data_word_t;
	typedef logic [1:0] byte_sel_t;	// {uds, lds}
	typedef logic [1:0] bus_slot_t;	// 8 MHz bus cycle number

	// four slots per bus cycle
	localparam bus_slot_t SLOT_PRE = 2'd0;	// before the cpu slot
	localparam bus_slot_t SLOT_CPU = 2'd1;	// cpu, blitter or download
	localparam bus_slot_t SLOT_VIDEO = 2'd2;	// shifter or viking fetch
	localparam bus_slot_t SLOT_IDLE = 2'd3;

	// MCU ROM chip selects, rom0..rom6 plus romp
	localparam int ROM_SEL_N = 8;
	localparam int ROM_TOS_IDX = 2;	// rom2 covers the TOS window

endpackage

/* st_map_pkg.sv */
/*
 * ST memory map package
 * address prefixes for TOS and Viking windows, Viking detector constants
 */
package st_map_pkg;

	// TOS download targets, compared against the top address bits
	localparam logic [5:0] TOS_HI_PREFIX = 6'b111111;	// 192k TOS at $fc0000
	localparam logic [3:0] TOS_LO_PREFIX = 4'he;	// 256k TOS at $e00000

	// ROM base for rom2 accesses, 17 offset bits go below it
	localparam logic [5:0] ROM256_BASE = {4'he, 2'b00};
	localparam logic [5:0] ROM192_BASE = {4'hf, 2'b11};

	// viking video memory window, top 6 address bits
	localparam logic [5:0] VIKING_BASE_ST = 6'b110000;	// $c00000
	localparam logic [5:0] VIKING_BASE_HIMEM = 6'b111010;	// $e80000

	typedef logic [7:0] viking_cnt_t;

	// accesses seen before the driver is taken as loaded
	localparam viking_cnt_t VIKING_THRESHOLD = 8'd255;

endpackage

/* ram_req_if.sv */
/*
 * SDRAM request bundle
 * one requester's address, strobes and write data towards the slot mux
 */
`timescale 1ns/1ps

interface ram_req_if;

	st_bus_pkg::word_addr_t addr;
	logic oe;	// read request
	logic we;	// write request
	st_bus_pkg::byte_sel_t ds;	// upper, lower
	st_bus_pkg::data_word_t wdata;

	// requester side drives everything
	modport req (output addr, output oe, output we, output ds, output wdata);

	// slot mux only looks
	modport mux (input addr, input oe, input we, input ds, input wdata);

endinterface

/* mcu_ram_strobe.sv */
/*
 * MCU RAM strobe generator
 * falling edge of the row strobe becomes a one cycle SDRAM read or write
 */
`timescale 1ns/1ps

module mcu_ram_strobe (
	input logic clk_32,
	input logic xsint,
	input st_bus_pkg::word_addr_t ram_a_i,	// MCU RAM address
	input logic ras_n_i,	// ras0_n & ras1_n
	input logic ram_we_n_i,
	input logic ram_uds_i,
	input logic ram_lds_i,
	input st_bus_pkg::data_word_t ram_din_i,	// from shifter data path
	ram_req_if.req req
);

	logic ras_n_d;	// ras one clock back
	logic ras_fall;

	// idles high so the first low cycle after reset is a real edge
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ras_n_d <= 1'b1;
		end else begin
			ras_n_d <= ras_n_i;
		end
	end

	assign ras_fall = ras_n_d & ~ras_n_i;	// first low cycle only

	// address zero is never read, the reset vector comes from ROM
	assign req.oe = ras_fall & ram_we_n_i & (|ram_a_i);
	assign req.we = ras_fall & ~ram_we_n_i;

	// payload straight from the MCU
	assign req.addr = ram_a_i;
	assign req.ds = {ram_uds_i, ram_lds_i};
	assign req.wdata = ram_din_i;

endmodule

/* dio_write_gen.sv */
/*
 * Download write generator
 * toggle strobe from the IO controller becomes one SDRAM write pulse
 */
`timescale 1ns/1ps

module dio_write_gen (
	input logic clk_32,
	input logic xsint,
	input st_bus_pkg::bus_slot_t bus_slot_i,
	input logic mhz8_en1_i,	// 8 MHz phase 1 enable
	input logic dio_strobe_i,	// toggles once per new word
	input st_bus_pkg::word_addr_t dio_addr_i,
	input st_bus_pkg::data_word_t dio_data_i,
	ram_req_if.req req
);

	logic strobe_d;	// last sampled toggle
	logic data_wr;	// write pulse
	logic sample_en;

	// sample only ahead of the cpu slot so the write lands there
	assign sample_en = (bus_slot_i == st_bus_pkg::SLOT_PRE) & mhz8_en1_i;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			strobe_d <= 1'b0;
			data_wr <= 1'b0;
		end else begin
			data_wr <= 1'b0;	// single cycle
			if (sample_en) begin
				strobe_d <= dio_strobe_i;
				if (dio_strobe_i ^ strobe_d)
					data_wr <= 1'b1;	// new word arrived
			end
		end
	end

	// download never reads, always full words
	assign req.we = data_wr;
	assign req.oe = 1'b0;
	assign req.ds = 2'b11;
	assign req.addr = dio_addr_i;
	assign req.wdata = dio_data_i;

endmodule

/* bus_slot_mux.sv */
/*
 * SDRAM bus slot multiplexer
 * per slot choice between download, blitter, viking and MCU requests
 */
`timescale 1ns/1ps

module bus_slot_mux (
	input st_bus_pkg::bus_slot_t bus_slot_i,
	input logic dio_download_i,	// firmware download running
	input logic blitter_bgack_i,	// blitter owns the bus
	input logic viking_active_i,	// viking driver detected
	ram_req_if.mux mcu,
	ram_req_if.mux dio,
	ram_req_if.mux blit,
	ram_req_if.mux vid,
	output st_bus_pkg::word_addr_t sdram_addr_o,
	output logic sdram_oe_o,
	output logic sdram_we_o,
	output st_bus_pkg::byte_sel_t sdram_ds_o,
	output st_bus_pkg::data_word_t sdram_din_o
);

	logic vid_fetch;	// viking takes the video slot

	assign vid_fetch = viking_active_i & vid.oe;

	// controller takes whatever is here, no handshake
	always_comb begin
		// MCU is the default owner of every slot
		sdram_addr_o = mcu.addr;
		sdram_oe_o = mcu.oe;
		sdram_we_o = mcu.we;
		sdram_ds_o = mcu.ds;

		case (bus_slot_i)
			st_bus_pkg::SLOT_CPU: begin
				if (dio_download_i) begin	// download beats everything
					sdram_addr_o = dio.addr;
					sdram_oe_o = 1'b0;	// write only path
					sdram_we_o = dio.we;
					sdram_ds_o = dio.ds;
				end else if (blitter_bgack_i) begin
					sdram_addr_o = blit.addr;
					sdram_oe_o = blit.oe;
					sdram_we_o = blit.we;
					sdram_ds_o = blit.ds;
				end
			end
			st_bus_pkg::SLOT_VIDEO: begin
				// shared with the shifter, viking only once active
				if (vid_fetch) begin
					sdram_addr_o = vid.addr;
					sdram_oe_o = vid.oe;
					sdram_we_o = vid.we;
					sdram_ds_o = vid.ds;
				end
			end
			default: begin
				// pre and idle slots stay with the MCU
			end
		endcase
	end

	// write data by bus owner, slot not involved
	always_comb begin
		if (dio_download_i)
			sdram_din_o = dio.wdata;
		else if (blitter_bgack_i)
			sdram_din_o = blit.wdata;
		else
			sdram_din_o = mcu.wdata;
	end

	// viking only reads, its data lane stays out of the mux

endmodule

/* tos_rom_map.sv */
/*
 * TOS ROM window mapper
 * tracks 192k or 256k TOS from download addresses, remaps rom2 accesses
 */
`timescale 1ns/1ps

module tos_rom_map (
	input logic clk_32,
	input logic xsint,
	input logic dio_download_i,
	input st_bus_pkg::word_addr_t dio_addr_i,	// download target
	input st_bus_pkg::word_addr_t cpu_a_i,
	input logic [st_bus_pkg::ROM_SEL_N-1:0] rom_sel_n_i,	// active low
	output logic rom_oe_o,
	output st_bus_pkg::word_addr_t rom_addr_o
);

	logic tos192k;	// 0 selects the 256k layout
	logic [5:0] rom_base;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			tos192k <= 1'b0;
		end else if (dio_download_i) begin
			if (dio_addr_i[23:18] == st_map_pkg::TOS_HI_PREFIX)
				tos192k <= 1'b1;	// writes to $fc0000 and up
			else if (dio_addr_i[23:20] == st_map_pkg::TOS_LO_PREFIX)
				tos192k <= 1'b0;	// writes to $e00000
		end
	end

	assign rom_base = tos192k ? st_map_pkg::ROM192_BASE : st_map_pkg::ROM256_BASE;

	// any select low means a ROM read
	assign rom_oe_o = ~(&rom_sel_n_i);

	// 128k word offset kept, top bits replaced for the TOS window
	assign rom_addr_o = !rom_sel_n_i[st_bus_pkg::ROM_TOS_IDX] ?
		{rom_base, cpu_a_i[17:1]} : cpu_a_i;

endmodule

/* viking_detect.sv */
/*
 * Viking activity detector
 * counts cpu accesses to the video window, switches video source at 255
 */
`timescale 1ns/1ps

module viking_detect (
	input logic clk_32,
	input logic xsint,
	input logic mhz8_en1_i,
	input logic as_n_i,	// cpu address strobe
	input logic viking_enable_i,
	input logic steroids_i,	// window moves to $e80000
	input st_bus_pkg::word_addr_t cpu_a_i,
	output logic viking_active_o
);

	st_map_pkg::viking_cnt_t viking_cnt;
	logic [5:0] win_base;
	logic in_window;
	logic cnt_en;

	assign win_base = steroids_i ? st_map_pkg::VIKING_BASE_HIMEM : st_map_pkg::VIKING_BASE_ST;
	assign in_window = (cpu_a_i[23:18] == win_base);

	// one count per 8 MHz tick of a qualifying access, saturates
	assign cnt_en = mhz8_en1_i & ~as_n_i & viking_enable_i & in_window &
		(viking_cnt < st_map_pkg::VIKING_THRESHOLD);

	// stray probes of the window stay below the threshold
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			viking_cnt <= '0;
			viking_active_o <= 1'b0;
		end else begin
			if (cnt_en)
				viking_cnt <= viking_cnt + 8'd1;
			viking_active_o <= (viking_cnt == st_map_pkg::VIKING_THRESHOLD);	// one clock late
		end
	end

endmodule

/* st_mem_glue.sv */
/*
 * ST memory glue top level
 * SDRAM requesters, slot mux, TOS mapper and Viking detector wired together
 */
`timescale 1ns/1ps

module st_mem_glue (
	input logic clk_32,
	input logic xsint,
	input st_bus_pkg::bus_slot_t bus_slot_i,
	input logic mhz8_en1_i,
	// MCU ram side
	input st_bus_pkg::word_addr_t ram_a_i,
	input logic ras_n_i,
	input logic ram_we_n_i,
	input logic ram_uds_i,
	input logic ram_lds_i,
	input st_bus_pkg::data_word_t ram_din_i,
	// blitter bus master
	input st_bus_pkg::word_addr_t blitter_addr_i,
	input logic blitter_read_i,
	input logic blitter_write_i,
	input logic blitter_bgack_i,
	input st_bus_pkg::data_word_t blitter_data_i,
	// viking video
	input st_bus_pkg::word_addr_t viking_vaddr_i,
	input logic viking_read_i,
	input logic viking_enable_i,
	input logic steroids_i,
	input logic as_n_i,
	// cpu and ROM
	input st_bus_pkg::word_addr_t cpu_a_i,
	input logic [st_bus_pkg::ROM_SEL_N-1:0] rom_sel_n_i,
	// IO controller download
	input logic dio_download_i,
	input logic dio_strobe_i,
	input st_bus_pkg::word_addr_t dio_addr_i,
	input st_bus_pkg::data_word_t dio_data_i,
	// SDRAM controller
	output st_bus_pkg::word_addr_t sdram_addr_o,
	output logic sdram_oe_o,
	output logic sdram_we_o,
	output st_bus_pkg::byte_sel_t sdram_ds_o,
	output st_bus_pkg::data_word_t sdram_din_o,
	output logic rom_oe_o,
	output st_bus_pkg::word_addr_t rom_addr_o,
	output logic viking_active_o
);

	logic viking_active;

	ram_req_if mcu_req ();
	ram_req_if dio_req ();
	ram_req_if blit_req ();
	ram_req_if vid_req ();

	mcu_ram_strobe mcu_ram_strobe_inst (
		.clk_32(clk_32), .xsint(xsint),
		.ram_a_i(ram_a_i), .ras_n_i(ras_n_i), .ram_we_n_i(ram_we_n_i),
		.ram_uds_i(ram_uds_i), .ram_lds_i(ram_lds_i), .ram_din_i(ram_din_i),
		.req(mcu_req.req)
	);

	dio_write_gen dio_write_gen_inst (
		.clk_32(clk_32), .xsint(xsint),
		.bus_slot_i(bus_slot_i), .mhz8_en1_i(mhz8_en1_i),
		.dio_strobe_i(dio_strobe_i), .dio_addr_i(dio_addr_i), .dio_data_i(dio_data_i),
		.req(dio_req.req)
	);

	// blitter always moves full words
	assign blit_req.addr = blitter_addr_i;
	assign blit_req.oe = blitter_read_i;
	assign blit_req.we = blitter_write_i;
	assign blit_req.ds = 2'b11;
	assign blit_req.wdata = blitter_data_i;

	// viking fetch is read only
	assign vid_req.addr = viking_vaddr_i;
	assign vid_req.oe = viking_read_i;
	assign vid_req.we = 1'b0;
	assign vid_req.ds = 2'b11;
	assign vid_req.wdata = '0;

	bus_slot_mux bus_slot_mux_inst (
		.bus_slot_i(bus_slot_i), .dio_download_i(dio_download_i),
		.blitter_bgack_i(blitter_bgack_i), .viking_active_i(viking_active),
		.mcu(mcu_req.mux), .dio(dio_req.mux), .blit(blit_req.mux), .vid(vid_req.mux),
		.sdram_addr_o(sdram_addr_o), .sdram_oe_o(sdram_oe_o), .sdram_we_o(sdram_we_o),
		.sdram_ds_o(sdram_ds_o), .sdram_din_o(sdram_din_o)
	);

	tos_rom_map tos_rom_map_inst (
		.clk_32(clk_32), .xsint(xsint),
		.dio_download_i(dio_download_i), .dio_addr_i(dio_addr_i),
		.cpu_a_i(cpu_a_i), .rom_sel_n_i(rom_sel_n_i),
		.rom_oe_o(rom_oe_o), .rom_addr_o(rom_addr_o)
	);

	viking_detect viking_detect_inst (
		.clk_32(clk_32), .xsint(xsint),
		.mhz8_en1_i(mhz8_en1_i), .as_n_i(as_n_i),
		.viking_enable_i(viking_enable_i), .steroids_i(steroids_i),
		.cpu_a_i(cpu_a_i), .viking_active_o(viking_active)
	);

	assign viking_active_o = viking_active;	// also picks the display source

endmodule

/* tb_st_mem_glue.sv */
/*
 * ST memory glue testbench
 * replays st_mem_trace.txt cycle by cycle and checks every DUT output
 */
`timescale 1ns/1ps

module tb_st_mem_glue;

	localparam int MAX_LINES = 64;

	logic clk_32 = 1'b0;
	logic xsint;
	st_bus_pkg::bus_slot_t bus_slot_i;
	logic mhz8_en1_i, ras_n_i, ram_we_n_i, ram_uds_i, ram_lds_i;
	st_bus_pkg::word_addr_t ram_a_i, blitter_addr_i, viking_vaddr_i, cpu_a_i, dio_addr_i;
	st_bus_pkg::data_word_t ram_din_i, blitter_data_i, dio_data_i;
	logic blitter_read_i, blitter_write_i, blitter_bgack_i;
	logic viking_read_i, viking_enable_i, steroids_i, as_n_i;
	logic [st_bus_pkg::ROM_SEL_N-1:0] rom_sel_n_i;
	logic dio_download_i, dio_strobe_i;
	st_bus_pkg::word_addr_t sdram_addr_o, rom_addr_o;
	logic sdram_oe_o, sdram_we_o, rom_oe_o, viking_active_o;
	st_bus_pkg::byte_sel_t sdram_ds_o;
	st_bus_pkg::data_word_t sdram_din_o;

	// one trace line, byte addresses in the file
	int rep_q [MAX_LINES];
	logic [1:0] slot_q [MAX_LINES];
	logic [13:0] iflag_q [MAX_LINES];	// en1 ras_n we_n uds lds brd bwr bgack vrd ven st as_n dl strobe
	logic [23:0] ram_a_q [MAX_LINES], blit_a_q [MAX_LINES], vaddr_q [MAX_LINES];
	logic [23:0] cpu_a_q [MAX_LINES], dio_a_q [MAX_LINES];
	logic [15:0] ram_d_q [MAX_LINES], blit_d_q [MAX_LINES], dio_d_q [MAX_LINES];
	logic [7:0] rom_sel_q [MAX_LINES];
	logic [23:0] exp_addr_q [MAX_LINES], exp_rom_q [MAX_LINES];
	logic [5:0] eflag_q [MAX_LINES];	// oe we uds lds rom_oe viking_active
	logic [15:0] exp_din_q [MAX_LINES];

	int n_lines = 0;
	int total_cycles = 0;
	int cycle_limit = 1000;
	int cycle_cnt = 0;
	int errors = 0;

	st_mem_glue st_mem_glue_inst (.*);

	always #10 clk_32 = ~clk_32;	// 20 ns

	// run guard, counts from reset release
	always @(posedge clk_32) begin
		if (xsint) begin
			cycle_cnt <= cycle_cnt + 1;
			if (cycle_cnt >= cycle_limit) begin
				$display("timeout: trace did not finish within %0d cycles", cycle_limit);
				$display("Done: errors found");
				$finish;
			end
		end
	end

	task automatic load_trace(output bit ok);
		int fd;
		int n;
		string line;
		ok = 1'b0;
		fd = $fopen("st_mem_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open st_mem_trace.txt");
			return;
		end
		while (!$feof(fd) && n_lines < MAX_LINES) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() < 8 || line.getc(0) == "#")
				continue;	// comment or blank
			n = $sscanf(line, "%d %h %b %h %h %h %h %h %h %h %h %h %h %b %h %h",
				rep_q[n_lines], slot_q[n_lines], iflag_q[n_lines], ram_a_q[n_lines],
				ram_d_q[n_lines], blit_a_q[n_lines], blit_d_q[n_lines], vaddr_q[n_lines],
				cpu_a_q[n_lines], rom_sel_q[n_lines], dio_a_q[n_lines], dio_d_q[n_lines],
				exp_addr_q[n_lines], eflag_q[n_lines], exp_din_q[n_lines], exp_rom_q[n_lines]);
			if (n != 16) begin
				$display("malformed trace line: %s", line);
				$fclose(fd);
				return;
			end
			total_cycles += rep_q[n_lines];
			n_lines++;
		end
		$fclose(fd);
		ok = (n_lines > 0);
		if (!ok)
			$display("trace file holds no cycles");
	endtask

	task automatic drive_line(input int i);
		bus_slot_i <= slot_q[i];
		{mhz8_en1_i, ras_n_i, ram_we_n_i, ram_uds_i, ram_lds_i} <= iflag_q[i][13:9];
		{blitter_read_i, blitter_write_i, blitter_bgack_i} <= iflag_q[i][8:6];
		{viking_read_i, viking_enable_i, steroids_i, as_n_i} <= iflag_q[i][5:2];
		{dio_download_i, dio_strobe_i} <= iflag_q[i][1:0];
		ram_a_i <= ram_a_q[i][23:1];
		ram_din_i <= ram_d_q[i];
		blitter_addr_i <= blit_a_q[i][23:1];
		blitter_data_i <= blit_d_q[i];
		viking_vaddr_i <= vaddr_q[i][23:1];
		cpu_a_i <= cpu_a_q[i][23:1];
		rom_sel_n_i <= rom_sel_q[i];
		dio_addr_i <= dio_a_q[i][23:1];
		dio_data_i <= dio_d_q[i];
	endtask

	task automatic check_outputs(input int i);
		assert (sdram_addr_o == exp_addr_q[i][23:1]) else begin
			$display("ERROR %0t: line %0d sdram addr %h, expected %h", $time, i,
				{sdram_addr_o, 1'b0}, exp_addr_q[i]);
			errors++;
		end
		assert ({sdram_oe_o, sdram_we_o, sdram_ds_o, rom_oe_o, viking_active_o} == eflag_q[i])
		else begin
			$display("ERROR %0t: line %0d flags %b, expected %b", $time, i,
				{sdram_oe_o, sdram_we_o, sdram_ds_o, rom_oe_o, viking_active_o}, eflag_q[i]);
			errors++;
		end
		assert (sdram_din_o == exp_din_q[i]) else begin
			$display("ERROR %0t: line %0d sdram din %h, expected %h", $time, i,
				sdram_din_o, exp_din_q[i]);
			errors++;
		end
		assert (rom_addr_o == exp_rom_q[i][23:1]) else begin
			$display("ERROR %0t: line %0d rom addr %h, expected %h", $time, i,
				{rom_addr_o, 1'b0}, exp_rom_q[i]);
			errors++;
		end
	endtask

	initial begin
		bit ok;
		xsint = 1'b0;
		bus_slot_i = st_bus_pkg::SLOT_IDLE;
		{mhz8_en1_i, ras_n_i, ram_we_n_i, ram_uds_i, ram_lds_i} = 5'b11111;	// MCU idle
		{blitter_read_i, blitter_write_i, blitter_bgack_i} = 3'b000;
		{viking_read_i, viking_enable_i, steroids_i, as_n_i} = 4'b0001;
		{dio_download_i, dio_strobe_i} = 2'b00;
		ram_a_i = '0;
		ram_din_i = '0;
		blitter_addr_i = '0;
		blitter_data_i = '0;
		viking_vaddr_i = '0;
		cpu_a_i = '0;
		rom_sel_n_i = '1;
		dio_addr_i = '0;
		dio_data_i = '0;
		load_trace(ok);
		if (!ok) begin
			$display("Done: errors found");
			$finish;
		end
		cycle_limit = total_cycles + 32;
		repeat (16) @(posedge clk_32);
		xsint <= 1'b1;
		for (int i = 0; i < n_lines; i++) begin
			for (int r = 0; r < rep_q[i]; r++) begin
				@(posedge clk_32);
				drive_line(i);
				@(negedge clk_32);	// outputs settled mid cycle
				check_outputs(i);
			end
		end
		@(posedge clk_32);
		$display("errors: %0d over %0d cycles", errors, total_cycles);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* tb.f */
st_bus_pkg.sv
st_map_pkg.sv
ram_req_if.sv
mcu_ram_strobe.sv
dio_write_gen.sv
bus_slot_mux.sv
tos_rom_map.sv
viking_detect.sv
st_mem_glue.sv
tb_st_mem_glue.sv

/* st_mem_trace.txt */
# rep slot flags(en1 ras_n we_n uds lds brd bwr bgack vrd ven st as_n dl strb) ram_a ram_d
# blit_a blit_d vaddr cpu_a rom_sel dio_a dio_d | sdram_addr flags(oe we ds rom_oe va) din rom
2 3 11111000000100 000100 1111 200000 2222 500000 012344 fb 300000 3333 000100 001110 1111 e12344
1 0 11111000000110 000100 1111 200000 2222 500000 000000 ff 300000 3333 000100 001100 3333 000000
1 0 11111000000111 000100 1111 200000 2222 500000 000000 ff 300000 3333 000100 001100 3333 000000
1 1 11111011000111 000100 1111 200000 2222 500000 000000 ff 300000 3333 300000 011100 3333 000000
1 1 11111011000111 000100 1111 200000 2222 500000 000000 ff 300000 3333 300000 001100 3333 000000
2 1 11111101000101 000100 1111 200000 2222 500000 000000 ff 300000 3333 200000 101100 2222 000000
1 1 11111100000101 000100 1111 200000 2222 500000 000000 ff 300000 3333 000100 001100 1111 000000
1 3 10111000000101 000100 1111 200000 2222 500000 000000 ff 300000 3333 000100 101100 1111 000000
2 3 10111000000101 000100 1111 200000 2222 500000 000000 ff 300000 3333 000100 001100 1111 000000
1 3 11111000000101 000100 1111 200000 2222 500000 000000 ff 300000 3333 000100 001100 1111 000000
1 3 10111000000101 000000 1111 200000 2222 500000 000000 ff 300000 3333 000000 001100 1111 000000
1 3 11111000000101 000000 1111 200000 2222 500000 000000 ff 300000 3333 000000 001100 1111 000000
1 3 10010000000101 000200 4444 200000 2222 500000 000000 ff 300000 3333 000200 011000 4444 000000
1 3 11111000000101 000100 1111 200000 2222 500000 000000 ff 300000 3333 000100 001100 1111 000000
1 3 11111000000111 000100 1111 200000 2222 500000 012344 fb fc0000 3333 000100 001110 3333 e12344
2 3 11111000000101 000100 1111 200000 2222 500000 012344 fb fc0000 3333 000100 001110 1111 fd2344
1 3 11111000000111 000100 1111 200000 2222 500000 012344 fb e00000 3333 000100 001110 3333 fd2344
1 3 11111000000101 000100 1111 200000 2222 500000 012344 fb e00000 3333 000100 001110 1111 e12344
10 3 11111000010001 000100 1111 200000 2222 500000 400000 ff 300000 3333 000100 001100 1111 400000
255 3 11111000010001 000100 1111 200000 2222 500000 c00000 ff 300000 3333 000100 001100 1111 c00000
1 3 11111000010101 000100 1111 200000 2222 500000 c00000 ff 300000 3333 000100 001100 1111 c00000
2 2 11111000110101 000100 1111 200000 2222 500000 c00000 ff 300000 3333 500000 101101 1111 c00000
1 2 11111000010101 000100 1111 200000 2222 500000 c00000 ff 300000 3333 000100 001101 1111 c00000
